// File: bench/tb_dac_stim.sv
`timescale 1ns/1ps
`default_nettype none
`include "dac_settings.svh"

module tb_dac_stim;

	typedef struct {
		string name;
		logic rst;
		dac_pkg::gen_mode_e mode;
		logic [15:0] seed;
		int pwl_len; // 0 keeps the table already loaded
		logic rdy_random;
		logic [31:0] rdy_mask; // bit (cycle % 32) drives dac_rdy
		int count;
	} test_row_t;

	localparam int NUM_ROWS = 7;

	logic clk = 1'b0;
	logic reset;
	dac_pkg::ps_cmd_t ps_cmd;
	logic ps_cmd_valid;
	logic dac_rdy;
	logic transfer_rdy;
	dac_pkg::dma_word_t dma_word;
	logic dma_valid;
	logic dma_ready;
	dac_pkg::dac_batch_t dac_batch;
	logic dac_batch_valid;
	dac_pkg::dac_status_t dac_status;
	logic dac_status_valid;

	test_row_t rows [NUM_ROWS];
	dac_pkg::dac_batch_t pwl_data [`PWL_DEPTH];
	dac_pkg::dac_batch_t lfsr_model;
	int pwl_len = 0;
	int errors = 0;
	int cycles = 0;
	int limit = 0;
	integer rand_seed;

	dac_stim_top dac_stim_top_i (
		.clk(clk),
		.reset(reset),
		.ps_cmd(ps_cmd),
		.ps_cmd_valid(ps_cmd_valid),
		.dac_rdy(dac_rdy),
		.transfer_rdy(transfer_rdy),
		.dma_word(dma_word),
		.dma_valid(dma_valid),
		.dma_ready(dma_ready),
		.dac_batch(dac_batch),
		.dac_batch_valid(dac_batch_valid),
		.dac_status(dac_status),
		.dac_status_valid(dac_status_valid)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout, the run went past its limit of %0d cycles", limit);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] v);
		return v[0] ? ((v >> 1) ^ 16'hB400) : (v >> 1);
	endfunction

	function automatic logic [`SAMPLE_WIDTH-1:0] tri_value(input int k);
		int m;
		m = k % (2 * `TRI_PEAK);
		return (m < `TRI_PEAK) ? `SAMPLE_WIDTH'(m) : `SAMPLE_WIDTH'(2 * `TRI_PEAK - 1 - m);
	endfunction

	task automatic fill_table();
		int sum;
		rows[0] = '{"lfsr_seed_1234", 1'b0, dac_pkg::MODE_LFSR, 16'h1234, 0, 1'b0, 32'hFFFF_FFFF, 40};
		rows[1] = '{"lfsr_zero_lane_gaps", 1'b0, dac_pkg::MODE_LFSR, 16'hFFFE, 0, 1'b0,
			32'hFFF0_00FF, 30};
		rows[2] = '{"tri_random_rdy", 1'b0, dac_pkg::MODE_TRI, 16'h0, 0, 1'b1, 32'h0, 140};
		rows[3] = '{"pwl_load_replay", 1'b0, dac_pkg::MODE_PWL, 16'h0, 6, 1'b0, 32'hFFFF_FFFF, 20};
		rows[4] = '{"pwl_restart_gaps", 1'b0, dac_pkg::MODE_PWL, 16'h0, 0, 1'b0, 32'hFF00_0FFF, 20};
		rows[5] = '{"tri_gaps", 1'b0, dac_pkg::MODE_TRI, 16'h0, 0, 1'b0, 32'hF000_FFFF, 30};
		rows[6] = '{"reset_cmd", 1'b1, dac_pkg::MODE_IDLE, 16'h0, 0, 1'b0, 32'hFFFF_FFFF, 0};
		sum = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			sum += rows[r].count;
		limit = 4 * sum + 200;
		for (int b = 0; b < `PWL_DEPTH; b++)
			for (int i = 0; i < `BATCH_SIZE; i++)
				pwl_data[b][i] = `SAMPLE_WIDTH'(b * 256 + i * 16 + 5);
	endtask

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic send_cmd(input logic rst, input logic halt, input dac_pkg::gen_mode_e mode,
		input logic [15:0] seed);
		ps_cmd.rst_cmd = rst;
		ps_cmd.halt_cmd = halt;
		ps_cmd.mode = mode;
		ps_cmd.seed = seed;
		ps_cmd_valid = 1'b1;
		tick();
		ps_cmd_valid = 1'b0;
		ps_cmd = '0;
	endtask

	// valid drops for one cycle after each accepted beat
	task automatic load_pwl(input int len);
		int b;
		logic gap;
		logic xfer;
		b = 0;
		gap = 1'b0;
		while (b < len) begin
			dma_valid = !gap;
			dma_word.data = pwl_data[b];
			dma_word.last = (b == len - 1);
			xfer = dma_valid && dma_ready;
			tick();
			gap = xfer;
			if (xfer)
				b++;
		end
		dma_valid = 1'b0;
		dma_word = '0;
	endtask

	task automatic wait_status(input logic want_ready);
		while (!(dac_status_valid === 1'b1 && dac_status.pwl_ready === want_ready))
			tick();
	endtask

	task automatic check_reset_idle();
		int err;
		err = 0;
		if (dac_batch_valid !== 1'b0 || dac_status_valid !== 1'b0 || dma_ready !== 1'b0) begin
			err++;
			$display("reset_idle: outputs not all low right after reset");
		end
		repeat (4) begin
			tick();
			if (dac_batch_valid !== 1'b0 || dac_status_valid !== 1'b0) begin
				err++;
				$display("reset_idle: a valid output rose with no command given");
			end
		end
		if (dma_ready !== 1'b1) begin
			err++;
			$display("reset_idle: dma_ready stayed low with the PWL player empty");
		end
		errors += err;
		$display("reset_idle: %s", (err == 0) ? "ok" : "failed");
	endtask

	task automatic run_row(input int r);
		int k;
		int cyc;
		int err;
		dac_pkg::dac_batch_t exp;
		k = 0;
		cyc = 0;
		err = 0;
		if (rows[r].pwl_len > 0) begin
			pwl_len = rows[r].pwl_len;
			transfer_rdy = 1'b0;
			load_pwl(pwl_len);
			if (dac_status_valid !== 1'b0) begin
				err++;
				$display("%s: status valid rose while transfer_rdy was low", rows[r].name);
			end
			transfer_rdy = 1'b1;
			wait_status(1'b1);
			if (dac_status.pwl_wave_period !== 32'(pwl_len * `BATCH_SIZE)) begin
				err++;
				$display("ERROR %s period expected %0d actual %0d", rows[r].name,
					pwl_len * `BATCH_SIZE, dac_status.pwl_wave_period);
			end
			tick();
			if (dac_status_valid !== 1'b0) begin
				err++;
				$display("%s: status valid stayed high after the host took it", rows[r].name);
			end
		end
		send_cmd(rows[r].rst, 1'b0, rows[r].mode, rows[r].seed);
		if (rows[r].rst) begin
			wait_status(1'b0);
			if (dac_status.pwl_wave_period !== 32'd0) begin
				err++;
				$display("ERROR %s period expected 0 actual %0d", rows[r].name,
					dac_status.pwl_wave_period);
			end
		end
		for (int i = 0; i < `BATCH_SIZE; i++) begin
			lfsr_model[i] = rows[r].seed + 16'(i);
			if (lfsr_model[i] == 16'h0)
				lfsr_model[i] = 16'h1; // all-zero lane is forced to 1
		end
		while (k < rows[r].count) begin
			if (dac_batch_valid === 1'b1) begin
				case (rows[r].mode)
					dac_pkg::MODE_LFSR: exp = lfsr_model;
					dac_pkg::MODE_TRI:
						for (int i = 0; i < `BATCH_SIZE; i++)
							exp[i] = tri_value(k * `BATCH_SIZE + i);
					default: exp = pwl_data[k % pwl_len];
				endcase
				if (dac_batch !== exp) begin
					err++;
					$display("ERROR %s batch %0d expected %h actual %h", rows[r].name, k, exp,
						dac_batch);
				end
				for (int i = 0; i < `BATCH_SIZE; i++)
					lfsr_model[i] = lfsr_next(lfsr_model[i]);
				k++;
			end
			if (rows[r].rdy_random)
				dac_rdy = ({$random(rand_seed)} % 4) != 0;
			else
				dac_rdy = rows[r].rdy_mask[cyc % 32];
			cyc++;
			tick();
		end
		dac_rdy = 1'b1;
		send_cmd(1'b0, 1'b1, dac_pkg::MODE_IDLE, 16'h0);
		repeat (`DAC_STAGES) tick(); // let the pipeline drain
		repeat (4) begin
			if (dac_batch_valid !== 1'b0) begin
				err++;
				$display("%s: batch valid still high after halt and drain", rows[r].name);
			end
			tick();
		end
		errors += err;
		$display("%s: %s, %0d batches checked", rows[r].name, (err == 0) ? "ok" : "failed", k);
	endtask

	initial begin
		rand_seed = 47517;
		reset = 1'b1;
		ps_cmd = '0;
		ps_cmd_valid = 1'b0;
		dac_rdy = 1'b1;
		transfer_rdy = 1'b0;
		dma_word = '0;
		dma_valid = 1'b0;
		fill_table();
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		check_reset_idle();
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("tests %0d, errors %0d, cycles %0d", NUM_ROWS + 1, errors, cycles);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/dac_pkg.sv
src/lfsr.sv
src/triangle_wave_gen.sv
src/stream_fifo.sv
pwl_generator/pwl_generator.sv
src/sample_generator.sv
src/dac_stim_top.sv
bench/tb_dac_stim.sv

// File: common/dac_pkg.sv
`default_nettype none
`include "dac_settings.svh"

package dac_pkg;

	typedef enum logic [1:0] {
		MODE_IDLE,
		MODE_LFSR,
		MODE_TRI,
		MODE_PWL
	} gen_mode_e;

	typedef enum logic [1:0] {
		PWL_EMPTY,
		PWL_LOAD,
		PWL_READY,
		PWL_RUN
	} pwl_state_e;

	typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

	typedef sample_t [`BATCH_SIZE-1:0] dac_batch_t; // lane 0 is the earliest sample

	// host command, a mode of MODE_LFSR always loads the seed
	typedef struct packed {
		sample_t seed;
		logic rst_cmd;
		logic halt_cmd;
		gen_mode_e mode;
	} ps_cmd_t;

	typedef struct packed {
		logic [31:0] pwl_wave_period;
		logic pwl_ready;
	} dac_status_t;

	typedef struct packed {
		dac_batch_t data;
		logic last; // closes a table load
	} dma_word_t;

endpackage

`default_nettype wire

// File: common/dac_settings.svh
`ifndef DAC_SETTINGS_SVH
`define DAC_SETTINGS_SVH

// sample and batch geometry
`define SAMPLE_WIDTH 16
`define BATCH_SIZE 4

`define DAC_STAGES 5 // output pipeline depth toward the DAC

// PWL table size in batches
`define PWL_DEPTH 64

`define DMA_FIFO_DEPTH 4

// triangle runs 0 .. TRI_PEAK-1 and back down
`define TRI_PEAK 256

`endif

// File: pwl_generator/pwl_generator.sv
`timescale 1ns/1ps
`default_nettype none
`include "dac_settings.svh"

module pwl_generator (
	input wire logic clk,
	input wire logic reset,
	input wire logic halt,
	input wire logic run,
	input wire dac_pkg::dma_word_t dma_word,
	input wire logic dma_valid,
	output logic dma_ready,
	output dac_pkg::dac_batch_t batch,
	output logic batch_valid,
	output logic ready,
	output logic [31:0] wave_period
);
	localparam int ADDR_W = $clog2(`PWL_DEPTH);
	localparam int CNT_W = ADDR_W + 1;

	dac_pkg::pwl_state_e state;
	dac_pkg::dac_batch_t table_mem [`PWL_DEPTH];
	logic [CNT_W-1:0] count; // batches stored, also the write address
	logic [ADDR_W-1:0] rd_addr;
	logic beat;
	logic at_end;
	logic rd_en;

	assign dma_ready = (state == dac_pkg::PWL_EMPTY) || (state == dac_pkg::PWL_LOAD);
	assign beat = dma_valid && dma_ready;
	assign at_end = ((CNT_W'(rd_addr) + 1'b1) == count);
	assign rd_en = (state == dac_pkg::PWL_RUN) && run && !halt;

	assign ready = (state == dac_pkg::PWL_READY) || (state == dac_pkg::PWL_RUN);
	assign wave_period = 32'(count) * 32'(`BATCH_SIZE);

	always_ff @(posedge clk) begin
		if (beat)
			table_mem[count[ADDR_W-1:0]] <= dma_word.data;
		if (rd_en)
			batch <= table_mem[rd_addr]; // one cycle read latency
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dac_pkg::PWL_EMPTY;
			count <= '0;
			rd_addr <= '0;
			batch_valid <= 1'b0;
		end else begin
			// beats only arrive in EMPTY and LOAD, so a halt never drops one
			if (beat) begin
				count <= count + 1'b1;
				if (dma_word.last)
					state <= dac_pkg::PWL_READY;
				else
					state <= dac_pkg::PWL_LOAD;
			end

			if (halt) begin
				rd_addr <= '0; // rewind, table stays
				batch_valid <= 1'b0;
				if (state == dac_pkg::PWL_RUN)
					state <= dac_pkg::PWL_READY;
			end else if (state == dac_pkg::PWL_READY && run) begin
				state <= dac_pkg::PWL_RUN;
			end else if (rd_en) begin
				batch_valid <= 1'b1;
				rd_addr <= at_end ? '0 : rd_addr + 1'b1;
			end
			// with run low the last read batch is held for the DAC
		end
	end

	a_table_bound: assert property (@(posedge clk) disable iff (reset)
		beat |-> (count < CNT_W'(`PWL_DEPTH)));

endmodule

`default_nettype wire

// File: src/dac_stim_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dac_settings.svh"

module dac_stim_top (
	input wire logic clk,
	input wire logic reset,
	input wire dac_pkg::ps_cmd_t ps_cmd,
	input wire logic ps_cmd_valid,
	input wire logic dac_rdy,
	input wire logic transfer_rdy,
	input wire dac_pkg::dma_word_t dma_word,
	input wire logic dma_valid,
	output logic dma_ready,
	output dac_pkg::dac_batch_t dac_batch,
	output logic dac_batch_valid,
	output dac_pkg::dac_status_t dac_status,
	output logic dac_status_valid
);
	dac_pkg::dma_word_t fifo_word; // FIFO to PWL player
	logic fifo_valid;
	logic fifo_ready;

	stream_fifo #(
		.DEPTH(`DMA_FIFO_DEPTH)
	) dma_fifo_i (
		.clk(clk),
		.reset(reset),
		.in_word(dma_word),
		.in_valid(dma_valid),
		.in_ready(dma_ready),
		.out_word(fifo_word),
		.out_valid(fifo_valid),
		.out_ready(fifo_ready)
	);

	sample_generator sample_generator_i (
		.clk(clk),
		.reset(reset),
		.ps_cmd(ps_cmd),
		.ps_cmd_valid(ps_cmd_valid),
		.dac_rdy(dac_rdy),
		.transfer_rdy(transfer_rdy),
		.dma_word(fifo_word),
		.dma_valid(fifo_valid),
		.dma_ready(fifo_ready),
		.dac_batch(dac_batch),
		.dac_batch_valid(dac_batch_valid),
		.dac_status(dac_status),
		.dac_status_valid(dac_status_valid)
	);

endmodule

`default_nettype wire

// File: src/lfsr.sv
`timescale 1ns/1ps
`default_nettype none
`include "dac_settings.svh"

module lfsr (
	input wire logic clk,
	input wire logic reset,
	input wire logic load,
	input wire logic [`SAMPLE_WIDTH-1:0] seed,
	input wire logic step,
	output logic [`SAMPLE_WIDTH-1:0] sample
);
	logic [`SAMPLE_WIDTH-1:0] shifted;

	// galois form of x^16 + x^14 + x^13 + x^11 + 1
	assign shifted = sample[0] ? ((sample >> 1) ^ `SAMPLE_WIDTH'(16'hB400)) : (sample >> 1);

	always_ff @(posedge clk) begin
		if (reset)
			sample <= '0;
		else if (load)
			sample <= (seed == '0) ? `SAMPLE_WIDTH'(1) : seed; // all-zero would lock up
		else if (step)
			sample <= shifted;
	end

endmodule

`default_nettype wire

// File: src/sample_generator.sv
`timescale 1ns/1ps
`default_nettype none
`include "dac_settings.svh"

module sample_generator (
	input wire logic clk,
	input wire logic reset,
	input wire dac_pkg::ps_cmd_t ps_cmd,
	input wire logic ps_cmd_valid,
	input wire logic dac_rdy,
	input wire logic transfer_rdy,
	input wire dac_pkg::dma_word_t dma_word,
	input wire logic dma_valid,
	output logic dma_ready,
	output dac_pkg::dac_batch_t dac_batch,
	output logic dac_batch_valid,
	output dac_pkg::dac_status_t dac_status,
	output logic dac_status_valid
);
	logic clear; // hardware reset or rst_cmd
	logic halt;
	logic load_seeds;
	dac_pkg::gen_mode_e mode;

	dac_pkg::dac_batch_t lfsr_batch;
	dac_pkg::dac_batch_t tri_batch;
	dac_pkg::dac_batch_t pwl_batch;
	dac_pkg::dac_batch_t src_batch;
	logic src_valid;
	logic lfsr_step;
	logic tri_step;
	logic pwl_run;
	logic pwl_valid;
	logic pwl_ready;
	logic [31:0] pwl_period;

	dac_pkg::dac_batch_t pipe_batch [`DAC_STAGES];
	logic [`DAC_STAGES-1:0] pipe_valid;
	dac_pkg::dac_status_t cur_status;

	assign clear = reset || (ps_cmd_valid && ps_cmd.rst_cmd);
	assign halt = ps_cmd_valid && ps_cmd.halt_cmd;
	assign load_seeds = ps_cmd_valid && !ps_cmd.rst_cmd && !ps_cmd.halt_cmd
		&& (ps_cmd.mode == dac_pkg::MODE_LFSR);

	// sources only move while the DAC is ready
	assign lfsr_step = (mode == dac_pkg::MODE_LFSR) && dac_rdy;
	assign tri_step = (mode == dac_pkg::MODE_TRI) && dac_rdy;
	assign pwl_run = (mode == dac_pkg::MODE_PWL) && dac_rdy;

	for (genvar i = 0; i < `BATCH_SIZE; i++) begin : lfsr_lanes
		lfsr lfsr_i (
			.clk(clk),
			.reset(clear || halt),
			.load(load_seeds),
			.seed(ps_cmd.seed + `SAMPLE_WIDTH'(i)), // lane i starts at seed + i
			.step(lfsr_step),
			.sample(lfsr_batch[i])
		);
	end

	triangle_wave_gen tri_gen_i (
		.clk(clk),
		.reset(clear || halt),
		.step(tri_step),
		.batch(tri_batch)
	);

	pwl_generator pwl_gen_i (
		.clk(clk),
		.reset(clear),
		.halt(halt),
		.run(pwl_run),
		.dma_word(dma_word),
		.dma_valid(dma_valid),
		.dma_ready(dma_ready),
		.batch(pwl_batch),
		.batch_valid(pwl_valid),
		.ready(pwl_ready),
		.wave_period(pwl_period)
	);

	always_ff @(posedge clk) begin
		if (clear || halt)
			mode <= dac_pkg::MODE_IDLE;
		else if (ps_cmd_valid)
			mode <= ps_cmd.mode;
	end

	always_comb begin
		src_batch = '0;
		src_valid = 1'b0;
		unique case (mode)
			dac_pkg::MODE_LFSR: begin
				src_batch = lfsr_batch;
				src_valid = dac_rdy;
			end
			dac_pkg::MODE_TRI: begin
				src_batch = tri_batch;
				src_valid = dac_rdy;
			end
			dac_pkg::MODE_PWL: begin
				src_batch = pwl_batch;
				src_valid = pwl_valid && dac_rdy; // held batch waits for ready
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		pipe_batch[0] <= src_batch;
		for (int s = 1; s < `DAC_STAGES; s++) begin
			pipe_batch[s] <= pipe_batch[s-1];
		end
	end

	// valid bits keep shifting so a halt drains what is already inside
	always_ff @(posedge clk) begin
		if (clear)
			pipe_valid <= '0;
		else
			pipe_valid <= {pipe_valid[`DAC_STAGES-2:0], src_valid};
	end

	assign dac_batch = pipe_batch[`DAC_STAGES-1];
	assign dac_batch_valid = pipe_valid[`DAC_STAGES-1];

	always_comb begin
		cur_status.pwl_wave_period = pwl_period;
		cur_status.pwl_ready = pwl_ready;
	end

	// a cleared table shows up as an ordinary status change
	always_ff @(posedge clk) begin
		if (reset) begin
			dac_status <= '0;
			dac_status_valid <= 1'b0;
		end else if (transfer_rdy) begin
			if (dac_status != cur_status) begin
				dac_status <= cur_status;
				dac_status_valid <= 1'b1;
			end else if (dac_status_valid) begin
				dac_status_valid <= 1'b0;
			end
		end
	end

	a_batch_valid_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(dac_batch_valid));

	a_status_on_transfer: assert property (@(posedge clk) disable iff (reset)
		$rose(dac_status_valid) |-> $past(transfer_rdy));

	// PWL batches only come out of a running player
	a_pwl_from_run: assert property (@(posedge clk) disable iff (reset)
		(mode == dac_pkg::MODE_PWL && pwl_valid) |-> (pwl_gen_i.state == dac_pkg::PWL_RUN));

endmodule

`default_nettype wire

// File: src/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
	parameter int DEPTH = 4
) (
	input wire logic clk,
	input wire logic reset,
	input wire dac_pkg::dma_word_t in_word,
	input wire logic in_valid,
	output logic in_ready,
	output dac_pkg::dma_word_t out_word,
	output logic out_valid,
	input wire logic out_ready
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH) + 1;

	dac_pkg::dma_word_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic wr_en;
	logic rd_en;

	function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign wr_en = in_valid && in_ready;
	assign rd_en = out_valid && out_ready;
	assign out_valid = (count != '0);
	assign out_word = mem[rd_ptr];

	always_comb begin
		count_next = count;
		if (wr_en && !rd_en)
			count_next = count + 1'b1;
		else if (rd_en && !wr_en)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= in_word;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in_ready <= 1'b0; // held low until the first cycle out of reset
		end else begin
			if (wr_en) wr_ptr <= bump(wr_ptr);
			if (rd_en) rd_ptr <= bump(rd_ptr);
			count <= count_next;
			in_ready <= (count_next < CNT_W'(DEPTH));
		end
	end

	// no write lands in a full FIFO
	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> (count < CNT_W'(DEPTH)));

endmodule

`default_nettype wire

// File: src/triangle_wave_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "dac_settings.svh"

module triangle_wave_gen (
	input wire logic clk,
	input wire logic reset,
	input wire logic step,
	output dac_pkg::dac_batch_t batch
);
	localparam int PERIOD = 2 * `TRI_PEAK;
	localparam int IDX_W = $clog2(PERIOD) + 1; // room for n + lane past the wrap

	logic [IDX_W-1:0] n; // index of lane 0, kept below PERIOD

	function automatic logic [`SAMPLE_WIDTH-1:0] fold(input logic [IDX_W-1:0] idx);
		logic [IDX_W-1:0] m;
		m = IDX_W'(idx % PERIOD);
		if (m < IDX_W'(`TRI_PEAK))
			fold = `SAMPLE_WIDTH'(m);
		else
			fold = `SAMPLE_WIDTH'(PERIOD - 1 - m); // falling half
	endfunction

	always_ff @(posedge clk) begin
		if (reset)
			n <= '0;
		else if (step)
			n <= IDX_W'((n + `BATCH_SIZE) % PERIOD);
	end

	always_comb begin
		for (int i = 0; i < `BATCH_SIZE; i++) begin
			batch[i] = fold(n + IDX_W'(i));
		end
	end

endmodule

`default_nettype wire
